// File: hw/pipe_pkg.sv
package pipe_pkg;

    // ------------------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------------------

    localparam int xlen       = 32;                 // Data and address width.
    localparam int reg_addr_w = 5;                  // Register index width.
    localparam int ram_words  = 256;                // Data memory depth in words.

    localparam int ram_addr_w = $clog2(ram_words);  // Word index width of the data memory.
    localparam int be_w       = xlen / 8;           // Byte lanes per word.

    // ------------------------------------------------------------------------
    // Memory access encodings
    // ------------------------------------------------------------------------

    // Kind of access carried by an operation into the memory stage.
    typedef enum logic [1:0] {
        MEM_NOP,                                    // Passes the result without an access.
        MEM_LOAD_S,                                 // Load with sign extension.
        MEM_LOAD_U,                                 // Load with zero extension.
        MEM_STORE
    } mem_type_t;

    typedef enum logic [1:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_t;

endpackage

// File: hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            in_valid,
    input  logic [pipe_pkg::xlen-1:0]       in_pc,
    input  logic [pipe_pkg::xlen-1:0]       in_result,
    input  logic [pipe_pkg::xlen-1:0]       in_store_data,
    input  pipe_pkg::mem_type_t             in_mem_type,
    input  pipe_pkg::mem_size_t             in_mem_size,
    input  logic [pipe_pkg::reg_addr_w-1:0] in_dest,
    output logic                            in_allowin,

    input  logic                            wb_stall,
    output logic                            mem_valid,
    output logic [pipe_pkg::xlen-1:0]       mem_pc,
    output logic [pipe_pkg::xlen-1:0]       mem_result,
    output pipe_pkg::mem_type_t             mem_mem_type,
    output pipe_pkg::mem_size_t             mem_mem_size,
    output logic [pipe_pkg::reg_addr_w-1:0] mem_dest,
    output logic                            mem_ready,

    output logic                            req,
    output logic                            req_we,
    output logic [pipe_pkg::xlen-1:0]       req_addr,
    output logic [pipe_pkg::xlen-1:0]       req_wdata,
    output logic [pipe_pkg::be_w-1:0]       req_be
);

    import pipe_pkg::*;

    logic [xlen-1:0] store_data_q;
    logic [xlen-1:0] lane_data;
    logic [be_w-1:0] lane_be;
    logic            accept;

    // The stage can take a new operation once its current one leaves.
    assign in_allowin = !mem_valid || !wb_stall;
    assign accept     = in_valid && in_allowin;
    assign mem_ready  = mem_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_valid <= 1'b0;
        end else if (in_allowin) begin
            mem_valid <= in_valid;              // Empties when nothing new arrives.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_pc       <= in_pc;
            mem_result   <= in_result;
            store_data_q <= in_store_data;
            mem_mem_type <= in_mem_type;
            mem_mem_size <= in_mem_size;
            mem_dest     <= in_dest;
        end
    end

    // ------------------------------------------------------------------------
    // Store lane placement
    // ------------------------------------------------------------------------

    always_comb begin
        case (mem_mem_size)
            MEM_BYTE: begin
                lane_data = {be_w{store_data_q[7:0]}};
                lane_be   = be_w'(1) << mem_result[1:0];
            end
            MEM_HALF: begin
                lane_data = {(be_w / 2){store_data_q[15:0]}};
                lane_be   = mem_result[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lane_data = store_data_q;
                lane_be   = '1;
            end
        endcase
    end

    // The request goes out in the same cycle the operation hands over.
    assign req       = mem_valid && (mem_mem_type != MEM_NOP) && !wb_stall;
    assign req_we    = (mem_mem_type == MEM_STORE);
    assign req_addr  = {2'b00, mem_result[xlen-1:2]};   // Word address without the low bits.
    assign req_wdata = lane_data;
    assign req_be    = lane_be;

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      req,
    input  logic                      req_we,
    input  logic [pipe_pkg::xlen-1:0] req_addr,
    input  logic [pipe_pkg::xlen-1:0] req_wdata,
    input  logic [pipe_pkg::be_w-1:0] req_be,

    output logic                      data_ok,
    output logic [pipe_pkg::xlen-1:0] rdata
);

    import pipe_pkg::*;

    logic [xlen-1:0]       mem [ram_words];
    logic [ram_addr_w-1:0] idx;

    assign idx = req_addr[ram_addr_w-1:0];  // Upper word address bits wrap.

    // data_ok stays up once a request has been served. Each new request
    // refreshes rdata on the next edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_ok <= 1'b0;
        end else if (req) begin
            data_ok <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rdata <= mem[idx];              // The old word is read on a store too.
            if (req_we) begin
                for (int i = 0; i < be_w; i++) begin
                    if (req_be[i]) begin
                        mem[idx][8*i +: 8] <= req_wdata[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: hw/wb_ctrl.sv
`timescale 1ns/1ps

module wb_ctrl (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            mem_ready,
    input  logic                            allowout,
    output logic                            wb_valid,
    output logic                            wb_ready,
    output logic                            wb_stall,

    input  logic                            mem_valid,
    input  logic [pipe_pkg::xlen-1:0]       mem_pc,
    input  logic [pipe_pkg::xlen-1:0]       mem_result,
    input  pipe_pkg::mem_type_t             mem_mem_type,
    input  pipe_pkg::mem_size_t             mem_mem_size,
    input  logic [pipe_pkg::reg_addr_w-1:0] mem_dest,

    input  logic                            mmu_data_ok,
    input  logic [pipe_pkg::xlen-1:0]       mmu_rdata,

    output logic                            rf_we,
    output logic [pipe_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [pipe_pkg::xlen-1:0]       rf_wdata,

    output logic                            wb_forwardable,
    output logic [pipe_pkg::xlen-1:0]       wb_pc,
    output logic [pipe_pkg::reg_addr_w-1:0] wb_dest,
    output logic [pipe_pkg::xlen-1:0]       wb_result
);

    import pipe_pkg::*;

    logic [xlen-1:0]       pc_q;
    logic [xlen-1:0]       result_q;
    mem_type_t             mem_type_q;
    mem_size_t             mem_size_q;
    logic [reg_addr_w-1:0] dest_q;

    logic [7:0]            load_b;
    logic [15:0]           load_h;
    logic                  sext;
    logic                  is_load;
    logic [xlen-1:0]       load_data;

    // Only a memory access has to wait for the RAM response.
    assign wb_ready = wb_valid && (mem_type_q == MEM_NOP || mmu_data_ok);
    assign wb_stall = wb_valid && (!wb_ready || !allowout);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (!wb_stall) begin
            wb_valid <= mem_valid && mem_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (!wb_stall) begin
            pc_q       <= mem_pc;
            result_q   <= mem_result;
            mem_type_q <= mem_mem_type;
            mem_size_q <= mem_mem_size;
            dest_q     <= mem_dest;
        end
    end

    // ------------------------------------------------------------------------
    // Load realignment and extension
    // ------------------------------------------------------------------------

    assign load_b  = mmu_rdata[8*result_q[1:0] +: 8];
    assign load_h  = mmu_rdata[16*result_q[1] +: 16];
    assign sext    = (mem_type_q == MEM_LOAD_S);
    assign is_load = (mem_type_q == MEM_LOAD_S) || (mem_type_q == MEM_LOAD_U);

    always_comb begin
        case (mem_size_q)
            MEM_BYTE: load_data = {{(xlen - 8){sext && load_b[7]}}, load_b};
            MEM_HALF: load_data = {{(xlen - 16){sext && load_h[15]}}, load_h};
            default:  load_data = mmu_rdata;
        endcase
    end

    assign wb_pc          = pc_q;
    assign wb_dest        = dest_q;
    assign wb_result      = is_load ? load_data : result_q;
    assign wb_forwardable = wb_ready;   // The value is final as soon as it is ready.

    assign rf_we    = wb_ready && allowout;
    assign rf_waddr = dest_q;
    assign rf_wdata = wb_result;

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            we,
    input  logic [pipe_pkg::reg_addr_w-1:0] waddr,
    input  logic [pipe_pkg::xlen-1:0]       wdata,

    input  logic [pipe_pkg::reg_addr_w-1:0] raddr_a,
    input  logic [pipe_pkg::reg_addr_w-1:0] raddr_b,
    output logic [pipe_pkg::xlen-1:0]       rdata_a,
    output logic [pipe_pkg::xlen-1:0]       rdata_b
);

    import pipe_pkg::*;

    // Register 0 has no storage.
    logic [xlen-1:0] regs [1:(1 << reg_addr_w) - 1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // A write shows on the read ports on the cycle after.
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// File: hw/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            in_valid,
    input  logic [pipe_pkg::xlen-1:0]       in_pc,
    input  logic [pipe_pkg::xlen-1:0]       in_result,
    input  logic [pipe_pkg::xlen-1:0]       in_store_data,
    input  pipe_pkg::mem_type_t             in_mem_type,
    input  pipe_pkg::mem_size_t             in_mem_size,
    input  logic [pipe_pkg::reg_addr_w-1:0] in_dest,
    output logic                            in_allowin,

    input  logic                            allowout,

    output logic                            commit_valid,
    output logic [pipe_pkg::xlen-1:0]       commit_pc,
    output logic [pipe_pkg::reg_addr_w-1:0] commit_dest,
    output logic [pipe_pkg::xlen-1:0]       commit_data,

    output logic                            fwd_valid,
    output logic [pipe_pkg::reg_addr_w-1:0] fwd_dest,
    output logic [pipe_pkg::xlen-1:0]       fwd_data,

    input  logic [pipe_pkg::reg_addr_w-1:0] dbg_raddr,
    output logic [pipe_pkg::xlen-1:0]       dbg_rdata
);

    import pipe_pkg::*;

    // ------------------------------------------------------------------------
    // Interconnect
    // ------------------------------------------------------------------------

    logic                  wb_stall;
    logic                  mem_valid;
    logic [xlen-1:0]       mem_pc;
    logic [xlen-1:0]       mem_result;
    mem_type_t             mem_mem_type;
    mem_size_t             mem_mem_size;
    logic [reg_addr_w-1:0] mem_dest;
    logic                  mem_ready;

    logic                  req;
    logic                  req_we;
    logic [xlen-1:0]       req_addr;
    logic [xlen-1:0]       req_wdata;
    logic [be_w-1:0]       req_be;
    logic                  data_ok;
    logic [xlen-1:0]       rdata;

    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    mem_stage u_mem_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .in_result     (in_result),
        .in_store_data (in_store_data),
        .in_mem_type   (in_mem_type),
        .in_mem_size   (in_mem_size),
        .in_dest       (in_dest),
        .in_allowin    (in_allowin),
        .wb_stall      (wb_stall),
        .mem_valid     (mem_valid),
        .mem_pc        (mem_pc),
        .mem_result    (mem_result),
        .mem_mem_type  (mem_mem_type),
        .mem_mem_size  (mem_mem_size),
        .mem_dest      (mem_dest),
        .mem_ready     (mem_ready),
        .req           (req),
        .req_we        (req_we),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_be        (req_be)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_we    (req_we),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_be    (req_be),
        .data_ok   (data_ok),
        .rdata     (rdata)
    );

    wb_ctrl u_wb_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_ready      (mem_ready),
        .allowout       (allowout),
        .wb_valid       (),
        .wb_ready       (),
        .wb_stall       (wb_stall),
        .mem_valid      (mem_valid),
        .mem_pc         (mem_pc),
        .mem_result     (mem_result),
        .mem_mem_type   (mem_mem_type),
        .mem_mem_size   (mem_mem_size),
        .mem_dest       (mem_dest),
        .mmu_data_ok    (data_ok),
        .mmu_rdata      (rdata),
        .rf_we          (rf_we),
        .rf_waddr       (rf_waddr),
        .rf_wdata       (rf_wdata),
        .wb_forwardable (fwd_valid),
        .wb_pc          (commit_pc),
        .wb_dest        (fwd_dest),
        .wb_result      (fwd_data)
    );

    // Port b waits for the decode stage.
    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .raddr_a (dbg_raddr),
        .raddr_b ('0),
        .rdata_a (dbg_rdata),
        .rdata_b ()
    );

    assign commit_valid = rf_we;        // A commit is exactly a register write.
    assign commit_dest  = rf_waddr;
    assign commit_data  = rf_wdata;

endmodule

// File: tests/tb_mem_wb.sv
`timescale 1ns/1ps

module tb_mem_wb;

    import pipe_pkg::*;

    logic                  clk           = 1'b0;
    logic                  rst_n         = 1'b0;
    logic                  in_valid      = 1'b0;
    logic [xlen-1:0]       in_pc         = '0;
    logic [xlen-1:0]       in_result     = '0;
    logic [xlen-1:0]       in_store_data = '0;
    mem_type_t             in_mem_type   = MEM_NOP;
    mem_size_t             in_mem_size   = MEM_WORD;
    logic [reg_addr_w-1:0] in_dest       = '0;
    logic                  allowout      = 1'b1;
    logic [reg_addr_w-1:0] dbg_raddr     = '0;

    logic                  in_allowin;
    logic                  commit_valid;
    logic [xlen-1:0]       commit_pc;
    logic [reg_addr_w-1:0] commit_dest;
    logic [xlen-1:0]       commit_data;
    logic                  fwd_valid;
    logic [reg_addr_w-1:0] fwd_dest;
    logic [xlen-1:0]       fwd_data;
    logic [xlen-1:0]       dbg_rdata;

    logic [xlen-1:0]       model_mem  [ram_words];
    logic [xlen-1:0]       model_regs [1 << reg_addr_w];
    logic [xlen-1:0]       exp_pc_q   [$];              // Expected commits in issue order.
    logic [reg_addr_w-1:0] exp_dest_q [$];
    logic [xlen-1:0]       exp_data_q [$];
    int                    exp_cyc_q  [$];              // Cycle of acceptance.

    int                    cyc           = 0;
    logic [xlen-1:0]       next_pc       = 32'h0000_1000;
    bit                    strict_timing = 1'b0;        // Latency must be exactly 2.
    bit                    bp_on         = 1'b0;        // Random back-pressure enable.

    mem_wb_top uut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(posedge clk) begin : drive_allowout
        logic [31:0] r;
        r = $urandom();
        allowout <= bp_on ? (r[1:0] != 2'b00) : 1'b1;
    end

    // ------------------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------------------

    task automatic stop_failed();
        $display("Verification failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        stop_failed();
    endtask

    task automatic error_out(string what);
        $display("Error at %0t: %s", $time, what);
        stop_failed();
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    function automatic logic [31:0] fill_word(logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    // Predicts the commit of the operation accepted at the coming edge.
    task automatic predict();
        logic [7:0]  idx;
        logic [31:0] word;
        logic [31:0] mask;
        logic [31:0] val;
        int          off;
        int          base;
        int          n;
        idx  = in_result[9:2];
        off  = int'(in_result[1:0]);
        word = model_mem[idx];
        case (in_mem_size)
            MEM_BYTE: begin
                n    = 1;
                base = off;
            end
            MEM_HALF: begin
                n    = 2;
                base = off & 2;                 // Realigned downward.
            end
            default: begin
                n    = 4;
                base = 0;
            end
        endcase
        mask = (n == 4) ? 32'hffff_ffff : ((32'd1 << (8 * n)) - 32'd1);
        val  = in_result;
        if (in_mem_type == MEM_STORE) begin
            for (int i = 0; i < 4; i++) begin
                if (i >= base && i < base + n) begin
                    word[8*i +: 8] = in_store_data[8*(i-base) +: 8];
                end
            end
            model_mem[idx] = word;
        end else if (in_mem_type != MEM_NOP) begin
            val = (word >> (8 * base)) & mask;
            if (in_mem_type == MEM_LOAD_S && val[8*n-1]) begin
                val = val | ~mask;
            end
        end
        exp_pc_q.push_back(in_pc);
        exp_dest_q.push_back(in_dest);
        exp_data_q.push_back(val);
        exp_cyc_q.push_back(cyc);
    endtask

    task automatic check_commit();
        if (exp_data_q.size() == 0) begin
            error_out("commit_valid high with no operation in flight");
        end else begin
            assert (allowout) else error_out("commit_valid high while allowout is low");
            assert (fwd_valid) else mismatch("fwd_valid", 32'(fwd_valid), 32'd1);
            assert (fwd_dest == commit_dest)
                else mismatch("fwd_dest", 32'(fwd_dest), 32'(commit_dest));
            assert (fwd_data == commit_data) else mismatch("fwd_data", fwd_data, commit_data);
            assert (commit_pc == exp_pc_q[0]) else mismatch("commit_pc", commit_pc, exp_pc_q[0]);
            assert (commit_dest == exp_dest_q[0])
                else mismatch("commit_dest", 32'(commit_dest), 32'(exp_dest_q[0]));
            assert (commit_data == exp_data_q[0])
                else mismatch("commit_data", commit_data, exp_data_q[0]);
            if (strict_timing) begin
                assert (cyc - exp_cyc_q[0] == 2)
                    else error_out($sformatf("pc 0x%08h committed %0d cycles after acceptance",
                                             commit_pc, cyc - exp_cyc_q[0]));
            end
            if (exp_dest_q[0] != '0) begin
                model_regs[exp_dest_q[0]] = exp_data_q[0];
            end
            void'(exp_pc_q.pop_front());
            void'(exp_dest_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_cyc_q.pop_front());
        end
    endtask

    // Outputs are sampled on the falling edge, half a cycle after inputs move.
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!commit_valid) else mismatch("commit_valid", 32'(commit_valid), 32'd0);
            assert (!fwd_valid) else mismatch("fwd_valid", 32'(fwd_valid), 32'd0);
        end else begin
            if (commit_valid) begin
                check_commit();
            end
            if (in_valid && in_allowin) begin
                predict();
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // Called on a rising edge, returns on the edge that accepts the operation.
    task automatic issue_op(mem_type_t t, mem_size_t s, logic [31:0] result,
                            logic [31:0] sdata, logic [4:0] dest);
        int waited;
        in_valid      <= 1'b1;
        in_pc         <= next_pc;
        in_result     <= result;
        in_store_data <= sdata;
        in_mem_type   <= t;
        in_mem_size   <= s;
        in_dest       <= dest;
        next_pc = next_pc + 32'd4;
        waited = 0;
        @(negedge clk);
        while (!in_allowin) begin
            if (waited > 50) begin
                error_out("in_allowin stayed low for 50 cycles");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
        @(posedge clk);
    endtask

    task automatic drain_pipe();
        int waited;
        in_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (exp_data_q.size() != 0) begin
            if (waited > 200) begin
                error_out("pipeline did not drain within 200 cycles");
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    task automatic check_regs();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            dbg_raddr <= 5'(i);
            @(negedge clk);
            assert (dbg_rdata == model_regs[5'(i)])
                else mismatch($sformatf("dbg_rdata[x%0d]", i), dbg_rdata, model_regs[5'(i)]);
        end
    endtask

    initial begin : main
        logic [31:0] r;
        logic [31:0] sd;
        logic [1:0]  o;
        mem_size_t   sz;
        void'($urandom(32'h29283bc9));
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        strict_timing = 1'b1;
        for (int i = 0; i < 12; i++) begin
            r = $urandom();
            issue_op(MEM_NOP, MEM_WORD, r, 32'd0, (i == 0) ? 5'd0 : r[12:8]);
        end
        drain_pipe();
        check_regs();

        @(posedge clk);
        for (int w = 0; w < 16; w++) begin
            r = $urandom();
            issue_op(MEM_STORE, MEM_WORD, 32'(w) << 2, fill_word(32'(w) << 2), r[4:0]);
        end
        for (int w = 0; w < 16; w++) begin
            r = $urandom();
            issue_op(r[8] ? MEM_LOAD_S : MEM_LOAD_U, MEM_WORD, (32'(w) << 2) | 32'(r[1:0]),
                     32'd0, r[4:0]);
        end
        drain_pipe();

        @(posedge clk);
        for (int k = 0; k < 4; k++) begin
            o = 2'(k);
            for (int h = 0; h < 2; h++) begin
                r  = $urandom();
                sd = o[0] ? (r | 32'h0000_8080) : (r & 32'hffff_7f7f);  // Both sign cases.
                sz = (h == 0) ? MEM_BYTE : MEM_HALF;
                issue_op(MEM_STORE, sz, {30'd4, o}, sd, r[20:16]);
                for (int d = -1; d < 2; d++) begin
                    r = $urandom();
                    issue_op(MEM_LOAD_S, sz, {30'd4, o + 2'(d)}, 32'd0, r[4:0]);
                    issue_op(MEM_LOAD_U, sz, {30'd4, o + 2'(d)}, 32'd0, r[12:8]);
                end
            end
            issue_op(MEM_LOAD_U, MEM_WORD, 32'd16, 32'd0, 5'd31);
        end
        drain_pipe();
        check_regs();

        strict_timing = 1'b0;
        bp_on         = 1'b1;
        @(posedge clk);
        for (int i = 0; i < 200; i++) begin
            r = $urandom();
            case (r[3:2])
                2'd0:    sz = MEM_BYTE;
                2'd1:    sz = MEM_HALF;
                default: sz = MEM_WORD;
            endcase
            sd = $urandom();
            issue_op(mem_type_t'(r[1:0]), sz, (r[1:0] == 2'd0) ? sd : {26'd0, r[13:8]},
                     $urandom(), r[20:16]);
            if (r[31:30] == 2'b00) begin
                in_valid <= 1'b0;                   // Bubble.
                @(posedge clk);
            end
        end
        drain_pipe();
        bp_on = 1'b0;
        check_regs();

        $display("Verification passed");
        $finish;
    end

endmodule

// File: files.f
hw/pipe_pkg.sv
hw/mem_stage.sv
hw/data_ram.sv
hw/wb_ctrl.sv
hw/reg_file.sv
hw/mem_wb_top.sv
tests/tb_mem_wb.sv

// File: Makefile
# Verilator build and run for the memory/writeback pipeline slice.

VERILATOR ?= verilator
TOP       ?= tb_mem_wb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes.
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status of the simulator is the result of the run.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
